// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// internal operation codes carried in oper_t
`define OP_ALU      5'd0
`define OP_ADDIU    5'd1
`define OP_LW       5'd2
`define OP_LL       5'd3
`define OP_SW       5'd4
`define OP_SC       5'd5
`define OP_BEQ      5'd6
`define OP_J        5'd7
`define OP_JR       5'd8
`define OP_MOVZ     5'd9
`define OP_MUL      5'd10
`define OP_SSNOP    5'd11
`define OP_MFC0     5'd12
`define OP_MTC0     5'd13
`define OP_ERET     5'd14

// major opcodes, bits 31:26
`define OPC_SPECIAL  6'h00
`define OPC_SPECIAL2 6'h1c
`define OPC_COP0     6'h10
`define OPC_ADDIU    6'h09
`define OPC_LW       6'h23
`define OPC_LL       6'h30
`define OPC_SW       6'h2b
`define OPC_SC       6'h38
`define OPC_BEQ      6'h04
`define OPC_J        6'h02

// function codes, bits 5:0
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_OR       6'h25
`define FN_JR       6'h08
`define FN_MOVZ     6'h0a
`define FN_MUL      6'h02
`define FN_ERET     6'h18

// cop0 sub-operations in the rs field
`define CP0_MF      5'b00000
`define CP0_MT      5'b00100

// sll zero, zero, 1
`define SSNOP_WORD  32'h0000_0040

`define QUEUE_DEPTH 4
`define PAGE_MASK   12'hfff
`define REG_ZERO    5'd0

`endif

// File: cpu_pkg.sv
package cpu_pkg;

	// instruction address as seen by fetch
	typedef logic [31:0] addr_t;

	// raw instruction word
	typedef logic [31:0] inst_t;

	// general register index
	typedef logic [4:0] reg_addr_t;

	// issue class of a decoded instruction, values are the OP_ macros
	typedef logic [4:0] oper_t;

	// queue occupancy, 0 to 4
	typedef logic [2:0] qcount_t;

endpackage

// File: inst_queue.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module inst_queue (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             fetch_valid,
	input  cpu_pkg::addr_t   fetch_pc,
	input  cpu_pkg::inst_t   fetch_inst,
	output logic             fetch_ready,
	input  logic             pop_one,
	input  logic             pop_two,
	output cpu_pkg::addr_t   head_pc,
	output cpu_pkg::inst_t   head_inst,
	output cpu_pkg::addr_t   next_pc,
	output cpu_pkg::inst_t   next_inst,
	output cpu_pkg::qcount_t count
);
	import cpu_pkg::*;

	addr_t      pc_mem   [`QUEUE_DEPTH];
	inst_t      inst_mem [`QUEUE_DEPTH];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [1:0] rd_ptr_next;
	logic       push;
	qcount_t    pop_cnt;

	assign fetch_ready = (count < qcount_t'(`QUEUE_DEPTH));
	assign push = fetch_valid && fetch_ready;

	// two oldest entries, next is stale when count < 2
	assign rd_ptr_next = rd_ptr + 2'd1;
	assign head_pc = pc_mem[rd_ptr];
	assign head_inst = inst_mem[rd_ptr];
	assign next_pc = pc_mem[rd_ptr_next];
	assign next_inst = inst_mem[rd_ptr_next];

	always_comb begin
		if (pop_two) begin
			pop_cnt = 3'd2;
		end else if (pop_one) begin
			pop_cnt = 3'd1;
		end else begin
			pop_cnt = 3'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= 2'd0;
			rd_ptr <= 2'd0;
			count <= 3'd0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 2'd1;
			end
			// pointers wrap at the depth of four
			rd_ptr <= rd_ptr + pop_cnt[1:0];
			count <= count + qcount_t'(push) - pop_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr] <= fetch_pc;
			inst_mem[wr_ptr] <= fetch_inst;
		end
	end

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module inst_decoder (
	input  cpu_pkg::inst_t     inst,
	output cpu_pkg::oper_t     op,
	output cpu_pkg::reg_addr_t rs,
	output cpu_pkg::reg_addr_t rt,
	output logic               we,
	output cpu_pkg::reg_addr_t waddr
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  field_rs;
	reg_addr_t  field_rt;
	reg_addr_t  field_rd;
	reg_addr_t  dest;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];
	assign field_rs = inst[25:21];
	assign field_rt = inst[20:16];
	assign field_rd = inst[15:11];

	// rs and rt report only the registers actually read, zero otherwise
	always_comb begin
		op = `OP_ALU;
		rs = `REG_ZERO;
		rt = `REG_ZERO;
		dest = `REG_ZERO;
		if (inst == `SSNOP_WORD) begin
			op = `OP_SSNOP;
		end else begin
			case (opcode)
				`OPC_SPECIAL: begin
					if (funct == `FN_ADDU || funct == `FN_SUBU || funct == `FN_OR) begin
						rs = field_rs;
						rt = field_rt;
						dest = field_rd;
					end else if (funct == `FN_JR) begin
						op = `OP_JR;
						rs = field_rs;
					end else if (funct == `FN_MOVZ) begin
						op = `OP_MOVZ;
						rs = field_rs;
						rt = field_rt;
						dest = field_rd;
					end
				end
				`OPC_SPECIAL2: begin
					if (funct == `FN_MUL) begin
						op = `OP_MUL;
						rs = field_rs;
						rt = field_rt;
						dest = field_rd;
					end
				end
				`OPC_COP0: begin
					// eret has the co bit set, mfc0 and mtc0 use the rs field
					if (inst[25] && funct == `FN_ERET) begin
						op = `OP_ERET;
					end else if (field_rs == `CP0_MF) begin
						op = `OP_MFC0;
						dest = field_rt;
					end else if (field_rs == `CP0_MT) begin
						op = `OP_MTC0;
						rt = field_rt;
					end
				end
				`OPC_ADDIU: begin
					op = `OP_ADDIU;
					rs = field_rs;
					dest = field_rt;
				end
				`OPC_LW, `OPC_LL: begin
					op = (opcode == `OPC_LW) ? `OP_LW : `OP_LL;
					rs = field_rs;
					dest = field_rt;
				end
				`OPC_SW, `OPC_SC: begin
					op = (opcode == `OPC_SW) ? `OP_SW : `OP_SC;
					rs = field_rs;
					rt = field_rt;
					// sc writes its success flag back to rt
					dest = (opcode == `OPC_SC) ? field_rt : `REG_ZERO;
				end
				`OPC_BEQ: begin
					op = `OP_BEQ;
					rs = field_rs;
					rt = field_rt;
				end
				`OPC_J: begin
					op = `OP_J;
				end
				default: begin
					op = `OP_ALU;
				end
			endcase
		end
	end

	assign we = (dest != `REG_ZERO);
	assign waddr = dest;

endmodule

// File: superscalar_ctrl.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module superscalar_ctrl (
	input  logic               rst_n,
	input  cpu_pkg::oper_t     op_a,
	input  cpu_pkg::oper_t     op_b,
	input  logic               we_a,
	input  cpu_pkg::reg_addr_t waddr_a,
	input  cpu_pkg::reg_addr_t rs_b,
	input  cpu_pkg::reg_addr_t rt_b,
	input  logic               delayslot,
	input  cpu_pkg::addr_t     pc_b,
	output logic               inst2_taken
);
	import cpu_pkg::*;

	function automatic logic is_read_mem(input oper_t op);
		return (op == `OP_LW || op == `OP_LL);
	endfunction

	function automatic logic is_write_mem(input oper_t op);
		return (op == `OP_SW || op == `OP_SC);
	endfunction

	function automatic logic is_jump(input oper_t op);
		return (op == `OP_BEQ || op == `OP_J || op == `OP_JR);
	endfunction

	function automatic logic is_privileged(input oper_t op);
		return (op == `OP_MFC0 || op == `OP_MTC0 || op == `OP_ERET);
	endfunction

	logic mem_a;
	logic mem_b;
	logic reg_related;

	assign mem_a = is_read_mem(op_a) || is_write_mem(op_a);
	assign mem_b = is_read_mem(op_b) || is_write_mem(op_b);

	// slot a result is a source of slot b, register zero never counts
	assign reg_related = we_a && (waddr_a != `REG_ZERO) &&
		(waddr_a == rs_b || waddr_a == rt_b);

	always_comb begin
		if (!rst_n) begin
			inst2_taken = 1'b0;
		end else if (op_a == `OP_SSNOP || op_b == `OP_SSNOP) begin
			inst2_taken = 1'b0;
		end else if (op_b == `OP_MOVZ && reg_related) begin
			// movz needs its operands at decode, a's result is too late
			inst2_taken = 1'b0;
		end else if (is_jump(op_b) || is_jump(op_a)) begin
			// branches live in pipe a and their delay slot issues alone
			inst2_taken = 1'b0;
		end else if (delayslot) begin
			inst2_taken = 1'b0;
		end else if (mem_a && mem_b) begin
			// one memory port
			inst2_taken = 1'b0;
		end else if ((is_read_mem(op_a) || op_a == `OP_SC) && reg_related) begin
			inst2_taken = 1'b0;
		end else if (is_privileged(op_a) || is_privileged(op_b)) begin
			// cp0 is reachable from pipe a only
			inst2_taken = 1'b0;
		end else if (op_a == `OP_MUL && reg_related) begin
			// mul result takes two cycles
			inst2_taken = 1'b0;
		end else if ((pc_b[11:0] & `PAGE_MASK) == 12'd0) begin
			// b may sit in another page than a
			inst2_taken = 1'b0;
		end else begin
			inst2_taken = 1'b1;
		end
	end

endmodule

// File: issue_latch.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module issue_latch (
	input  logic             clk,
	input  logic             rst_n,
	input  cpu_pkg::qcount_t count,
	input  logic             inst2_taken,
	input  cpu_pkg::oper_t   op_a,
	input  logic             issue_ready,
	input  cpu_pkg::addr_t   head_pc,
	input  cpu_pkg::addr_t   next_pc,
	input  cpu_pkg::inst_t   head_inst,
	input  cpu_pkg::inst_t   next_inst,
	output logic             pop_one,
	output logic             pop_two,
	output logic             delayslot,
	output logic             a_valid,
	output cpu_pkg::addr_t   a_pc,
	output cpu_pkg::inst_t   a_inst,
	output logic             a_delayslot,
	output logic             b_valid,
	output cpu_pkg::addr_t   b_pc,
	output cpu_pkg::inst_t   b_inst
);
	logic issue;

	assign issue = issue_ready && (count != 3'd0);
	assign pop_two = issue && inst2_taken && (count >= 3'd2);
	assign pop_one = issue && !pop_two;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_valid <= 1'b0;
			b_valid <= 1'b0;
			a_delayslot <= 1'b0;
			delayslot <= 1'b0;
		end else if (issue_ready) begin
			a_valid <= issue;
			b_valid <= pop_two;
			if (issue) begin
				a_delayslot <= delayslot;
				// a branch in pipe a makes the next popped instruction its delay slot
				delayslot <= (op_a == `OP_BEQ || op_a == `OP_J || op_a == `OP_JR);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			a_pc <= head_pc;
			a_inst <= head_inst;
		end
		if (pop_two) begin
			b_pc <= next_pc;
			b_inst <= next_inst;
		end
	end

endmodule

// File: dual_issue.sv
`timescale 1ns/1ps

module dual_issue (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           fetch_valid,
	input  cpu_pkg::addr_t fetch_pc,
	input  cpu_pkg::inst_t fetch_inst,
	output logic           fetch_ready,
	input  logic           issue_ready,
	output logic           a_valid,
	output cpu_pkg::addr_t a_pc,
	output cpu_pkg::inst_t a_inst,
	output logic           a_delayslot,
	output logic           b_valid,
	output cpu_pkg::addr_t b_pc,
	output cpu_pkg::inst_t b_inst
);
	import cpu_pkg::*;

	addr_t     head_pc;
	addr_t     next_pc;
	inst_t     head_inst;
	inst_t     next_inst;
	qcount_t   count;
	logic      pop_one;
	logic      pop_two;
	oper_t     op_a;
	oper_t     op_b;
	logic      we_a;
	reg_addr_t waddr_a;
	reg_addr_t rs_b;
	reg_addr_t rt_b;
	logic      delayslot;
	logic      inst2_taken;

	inst_queue queue_i (
		.clk(clk), .rst_n(rst_n),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst), .fetch_ready(fetch_ready),
		.pop_one(pop_one), .pop_two(pop_two),
		.head_pc(head_pc), .head_inst(head_inst),
		.next_pc(next_pc), .next_inst(next_inst),
		.count(count)
	);

	// pairing looks only at slot a's write and slot b's reads
	inst_decoder dec_a_i (
		.inst(head_inst), .op(op_a), .rs(), .rt(), .we(we_a), .waddr(waddr_a)
	);

	inst_decoder dec_b_i (
		.inst(next_inst), .op(op_b), .rs(rs_b), .rt(rt_b), .we(), .waddr()
	);

	superscalar_ctrl ctrl_i (
		.rst_n(rst_n), .op_a(op_a), .op_b(op_b),
		.we_a(we_a), .waddr_a(waddr_a), .rs_b(rs_b), .rt_b(rt_b),
		.delayslot(delayslot), .pc_b(next_pc), .inst2_taken(inst2_taken)
	);

	issue_latch latch_i (
		.clk(clk), .rst_n(rst_n), .count(count),
		.inst2_taken(inst2_taken), .op_a(op_a), .issue_ready(issue_ready),
		.head_pc(head_pc), .next_pc(next_pc),
		.head_inst(head_inst), .next_inst(next_inst),
		.pop_one(pop_one), .pop_two(pop_two), .delayslot(delayslot),
		.a_valid(a_valid), .a_pc(a_pc), .a_inst(a_inst), .a_delayslot(a_delayslot),
		.b_valid(b_valid), .b_pc(b_pc), .b_inst(b_inst)
	);

endmodule

// File: dual_issue_assertions.sv
`timescale 1ns/1ps

module dual_issue_assertions (
	input logic             clk,
	input logic             rst_n,
	input logic             fetch_ready,
	input cpu_pkg::qcount_t count,
	input logic             issue_ready,
	input logic             a_valid,
	input logic             b_valid,
	input cpu_pkg::inst_t   a_inst,
	input cpu_pkg::inst_t   b_inst
);

	// pipe b never issues without pipe a
	b_needs_a: assert property (@(posedge clk) disable iff (!rst_n) b_valid |-> a_valid)
		else $error("b_valid high while a_valid low");

	// occupancy stays within four entries and fetch is open below that
	fetch_open: assert property (@(posedge clk) disable iff (!rst_n)
		(count <= 3'd4) && ((count < 3'd4) == fetch_ready))
		else $error("queue occupancy out of range or fetch_ready wrong");

	// stalled issue keeps the registered pair
	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		($past(rst_n) && !$past(issue_ready)) |->
		($stable(a_valid) && $stable(b_valid) && $stable(a_inst) && $stable(b_inst)))
		else $error("issue outputs changed during back-pressure");

	reset_clear: assert property (@(posedge clk) !rst_n |=> (!a_valid && !b_valid))
		else $error("valid outputs high after reset");

endmodule

// File: dual_issue_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dual_issue_tb;
	import cpu_pkg::*;

	logic  clk;
	logic  rst_n;
	logic  fetch_valid;
	addr_t fetch_pc;
	inst_t fetch_inst;
	logic  fetch_ready;
	logic  issue_ready;
	logic  a_valid;
	addr_t a_pc;
	inst_t a_inst;
	logic  a_delayslot;
	logic  b_valid;
	addr_t b_pc;
	inst_t b_inst;

	// per row: slot a word, slot b word, optional third word, pc of b, pairing, delay slot of b
	inst_t tab_w1 [20];
	inst_t tab_w2 [20];
	inst_t tab_w3 [20];
	addr_t tab_pc2 [20];
	logic  tab_pair [20];
	logic  tab_ds2 [20];
	int    num_rows;
	int    errors;
	int    tests;
	int    passed;
	int    cycles;
	int    limit;
	int    seed;

	dual_issue dut_i (
		.clk(clk), .rst_n(rst_n),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst),
		.fetch_ready(fetch_ready), .issue_ready(issue_ready),
		.a_valid(a_valid), .a_pc(a_pc), .a_inst(a_inst), .a_delayslot(a_delayslot),
		.b_valid(b_valid), .b_pc(b_pc), .b_inst(b_inst)
	);

	bind dual_issue dual_issue_assertions asrt_i (
		.clk(clk), .rst_n(rst_n), .fetch_ready(fetch_ready), .count(count),
		.issue_ready(issue_ready), .a_valid(a_valid), .b_valid(b_valid),
		.a_inst(a_inst), .b_inst(b_inst)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, issue stage stopped responding", cycles);
			$display("Errors found");
			$finish;
		end
	end

	function automatic inst_t rtype(input reg_addr_t rs, rt, rd, input logic [5:0] fn);
		return {`OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic inst_t itype(input logic [5:0] opc, input reg_addr_t rs, rt,
		input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	task automatic add_row(input inst_t w1, w2, w3, input addr_t pc2, input logic pair, ds2);
		tab_w1[num_rows] = w1;
		tab_w2[num_rows] = w2;
		tab_w3[num_rows] = w3;
		tab_pc2[num_rows] = pc2;
		tab_pair[num_rows] = pair;
		tab_ds2[num_rows] = ds2;
		num_rows++;
	endtask

	task automatic check_word(input string name, input inst_t got, exp);
		assert (got === exp) else begin
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		assert (got === exp) else begin
			$display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic push_word(input addr_t pc, input inst_t w);
		@(posedge clk);
		fetch_valid <= 1'b1;
		fetch_pc <= pc;
		fetch_inst <= w;
	endtask

	task automatic run_row(input int r);
		inst_t words [3];
		addr_t pcs [3];
		int    n;
		int    idx;
		int    i;
		int    err_start;
		logic  exp_b;
		err_start = errors;
		words[0] = tab_w1[r];
		words[1] = tab_w2[r];
		words[2] = tab_w3[r];
		pcs[0] = tab_pc2[r] - 32'd4;
		pcs[1] = tab_pc2[r];
		pcs[2] = tab_pc2[r] + 32'd4;
		n = (tab_w3[r] != 32'd0) ? 3 : 2;
		// fill the queue while issue is stalled so both words are present together
		for (i = 0; i < n; i++) begin
			push_word(pcs[i], words[i]);
		end
		@(posedge clk);
		fetch_valid <= 1'b0;
		issue_ready <= 1'b1;
		idx = 0;
		while (idx < n) begin
			@(negedge clk);
			if (a_valid) begin
				exp_b = (idx == 0) ? tab_pair[r] : 1'b0;
				check_word("a_inst", a_inst, words[idx]);
				check_word("a_pc", a_pc, pcs[idx]);
				check_flag("b_valid", b_valid, exp_b);
				if (exp_b && b_valid) begin
					check_word("b_inst", b_inst, words[idx + 1]);
					check_word("b_pc", b_pc, pcs[idx + 1]);
				end
				if (idx == 1) begin
					check_flag("a_delayslot", a_delayslot, tab_ds2[r]);
				end
				idx += exp_b ? 2 : 1;
			end
		end
		@(posedge clk);
		issue_ready <= 1'b0;
		tests++;
		if (errors == err_start) begin
			passed++;
		end
		$display("row %0d: %s", r, (errors == err_start) ? "ok" : "mismatch");
	endtask

	task automatic run_backpressure();
		inst_t words [4];
		int    hold;
		int    i;
		int    err_start;
		err_start = errors;
		words[0] = rtype(5'd1, 5'd2, 5'd3, `FN_ADDU);
		words[1] = rtype(5'd7, 5'd8, 5'd6, `FN_ADDU);
		words[2] = rtype(5'd11, 5'd12, 5'd13, `FN_SUBU);
		words[3] = rtype(5'd14, 5'd15, 5'd16, `FN_OR);
		for (i = 0; i < 4; i++) begin
			push_word(32'h3000 + 32'(4 * i + 4), words[i]);
		end
		@(posedge clk);
		fetch_valid <= 1'b0;
		issue_ready <= 1'b1;
		// four entries held, fetch must be refused
		@(negedge clk);
		check_flag("fetch_ready", fetch_ready, 1'b0);
		@(posedge clk);
		issue_ready <= 1'b0;
		hold = 1 + ($unsigned($random(seed)) % 8);
		repeat (hold) begin
			@(negedge clk);
			check_flag("a_valid", a_valid, 1'b1);
			check_flag("b_valid", b_valid, 1'b1);
			check_word("a_inst", a_inst, words[0]);
			check_word("b_inst", b_inst, words[1]);
		end
		@(posedge clk);
		issue_ready <= 1'b1;
		@(negedge clk);
		@(negedge clk);
		check_flag("a_valid", a_valid, 1'b1);
		check_flag("b_valid", b_valid, 1'b1);
		check_word("a_inst", a_inst, words[2]);
		check_word("b_inst", b_inst, words[3]);
		// queue drained, nothing further may appear
		@(negedge clk);
		check_flag("a_valid", a_valid, 1'b0);
		@(posedge clk);
		issue_ready <= 1'b0;
		tests++;
		if (errors == err_start) begin
			passed++;
		end
		$display("back-pressure hold %0d cycles: %s", hold,
			(errors == err_start) ? "ok" : "mismatch");
	endtask

	initial begin
		int r;
		clk = 1'b0;
		rst_n = 1'b0;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fetch_inst = '0;
		issue_ready = 1'b0;
		errors = 0;
		tests = 0;
		passed = 0;
		cycles = 0;
		num_rows = 0;
		seed = 22029;
		limit = 1000;
		add_row(rtype(1, 2, 3, `FN_ADDU), rtype(7, 8, 6, `FN_ADDU), 0, 32'h104, 1, 0);
		add_row(rtype(1, 2, 3, `FN_ADDU), rtype(3, 4, 5, `FN_SUBU), 0, 32'h114, 1, 0);
		add_row(itype(`OPC_LW, 1, 9, 0), rtype(7, 8, 6, `FN_ADDU), 0, 32'h124, 1, 0);
		add_row(`SSNOP_WORD, rtype(7, 8, 6, `FN_ADDU), 0, 32'h134, 0, 0);
		add_row(rtype(1, 2, 3, `FN_ADDU), `SSNOP_WORD, 0, 32'h144, 0, 0);
		add_row(itype(`OPC_LW, 1, 9, 0), itype(`OPC_SW, 2, 10, 0), 0, 32'h154, 0, 0);
		add_row(itype(`OPC_LW, 1, 9, 0), rtype(9, 8, 6, `FN_ADDU), 0, 32'h164, 0, 0);
		add_row(itype(`OPC_SC, 1, 9, 0), rtype(7, 9, 6, `FN_ADDU), 0, 32'h174, 0, 0);
		add_row({`OPC_SPECIAL2, 5'd1, 5'd2, 5'd3, 5'd0, `FN_MUL}, rtype(3, 8, 6, `FN_ADDU),
			0, 32'h184, 0, 0);
		add_row(rtype(1, 2, 3, `FN_ADDU), rtype(3, 8, 6, `FN_MOVZ), 0, 32'h194, 0, 0);
		add_row({`OPC_COP0, `CP0_MF, 5'd4, 5'd12, 11'd0}, rtype(7, 8, 6, `FN_ADDU),
			0, 32'h1a4, 0, 0);
		add_row(rtype(1, 2, 3, `FN_ADDU), {`OPC_COP0, `CP0_MT, 5'd5, 5'd12, 11'd0},
			0, 32'h1b4, 0, 0);
		add_row({`OPC_COP0, 1'b1, 19'd0, `FN_ERET}, rtype(7, 8, 6, `FN_ADDU), 0, 32'h1c4, 0, 0);
		// jump in a, its delay slot must not pair with the word behind it
		add_row({`OPC_J, 26'h40}, rtype(7, 8, 6, `FN_ADDU), rtype(11, 12, 10, `FN_ADDU),
			32'h1d4, 0, 1);
		add_row(rtype(1, 2, 3, `FN_ADDU), itype(`OPC_BEQ, 1, 2, 4), rtype(11, 12, 10, `FN_ADDU),
			32'h1e4, 0, 0);
		add_row(rtype(31, 0, 0, `FN_JR), rtype(7, 8, 6, `FN_ADDU), rtype(11, 12, 10, `FN_ADDU),
			32'h1f4, 0, 1);
		add_row(rtype(1, 2, 3, `FN_ADDU), rtype(7, 8, 6, `FN_ADDU), 0, 32'h2000, 0, 0);
		add_row(rtype(1, 2, 0, `FN_ADDU), itype(`OPC_LW, 0, 9, 0), 0, 32'h214, 1, 0);
		// load into register zero does not feed b
		add_row(itype(`OPC_LW, 1, 0, 0), rtype(0, 8, 6, `FN_ADDU), 0, 32'h224, 1, 0);
		limit = (num_rows + 1) * 20 + 16;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (r = 0; r < num_rows; r++) begin
			run_row(r);
		end
		run_backpressure();
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests, passed, tests - passed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
cpu_pkg.sv
inst_queue.sv
inst_decoder.sv
superscalar_ctrl.sv
issue_latch.sv
dual_issue.sv
dual_issue_assertions.sv
dual_issue_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f sources.f --top-module dual_issue_tb -o dual_issue_sim \
	&& ./obj_dir/dual_issue_sim | tee /dev/stderr | grep -q "No errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
